// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = arcade_shell_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) source/arcade_shell_consts.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/arcade_shell_consts.svh
// Constants of the arcade shell: download targets, switch bank, reset stretch, aspect, status bits

`ifndef ARCADE_SHELL_CONSTS_SVH
`define ARCADE_SHELL_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Host download targets
//////////////////////////////////////////////////////////////////////

// ROM image
`define ARCADE_DL_INDEX_ROM 8'd0
// Game variant byte
`define ARCADE_DL_INDEX_MOD 8'd1
// DIP switch bank
`define ARCADE_DL_INDEX_DIP 8'd254

// Switch bytes kept by the decoder, only the first two reach the core
`define ARCADE_DIP_BYTES 8

// Core reset held this many cycles after the last source drops
`define ARCADE_RESET_STRETCH 16

// Native 4:3 monitor
`define ARCADE_ARX_ORIG 12'd4
`define ARCADE_ARY_ORIG 12'd3

//////////////////////////////////////////////////////////////////////
// Status word bit positions
//////////////////////////////////////////////////////////////////////

`define ARCADE_STAT_RESET 0
`define ARCADE_STAT_SELFTEST 3
// Low bit of the two-bit aspect field
`define ARCADE_STAT_AR_LO 14

`endif

// File: source/arcade_shell_pkg.sv
// Shared types of the arcade shell: bus widths, audio and video widths, reset states

package arcade_shell_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	// Host data, DIP and button bytes
	typedef logic [7:0] byte_t;

	// One joystick word from the host
	typedef logic [15:0] joy_t;

	// Download address, covers the whole ROM space
	typedef logic [24:0] dl_addr_t;

	// Download target selector
	typedef logic [7:0] dl_index_t;

	// Menu option bits
	typedef logic [31:0] status_t;

	//////////////////////////////////////////////////////////////////////
	// Video and audio
	//////////////////////////////////////////////////////////////////////

	// One component of the HDMI aspect ratio
	typedef logic [11:0] ratio_t;

	// Output sample, unsigned
	typedef logic [15:0] sample_t;

	// Raw level from the game core
	typedef logic [3:0] game_audio_t;

	// Core reset sequencing
	typedef enum logic [1:0] {
		RST_HOLD,
		RST_STRETCH,
		RST_RUN
	} reset_state_t;

endpackage

// File: source/arcade_shell_top.sv
// Arcade shell top level: download decoder, stick mapper and shell control

module arcade_shell_top
	import arcade_shell_pkg::*;
(
	input  logic        clk_25,
	input  logic        rst_n,

	// Host download bus
	input  logic        dl_download,
	input  logic        dl_wr,
	input  dl_addr_t    dl_addr,
	input  dl_index_t   dl_index,
	input  byte_t       dl_data,

	// Host menu and controls
	input  status_t     status,
	input  logic [1:0]  buttons,
	input  joy_t        joy_0,
	input  joy_t        joy_1,

	// From the game core
	input  game_audio_t game_audio,

	// To the game core
	output logic        rom_wr,
	output dl_addr_t    rom_addr,
	output byte_t       rom_data,
	output byte_t       dsw0,
	output byte_t       dsw1,
	output logic        game_battlezone,
	output logic        game_bradley,
	output logic        game_redbaron,
	output byte_t       cab_buttons,
	output logic        self_test,
	output logic        core_rst_n,

	// To the video scaler and audio path
	output ratio_t      video_arx,
	output ratio_t      video_ary,
	output logic        ce_pix,
	output sample_t     audio_l,
	output sample_t     audio_r,
	output logic        led_user
);

	//////////////////////////////////////////////////////////////////////
	// Download decode
	//////////////////////////////////////////////////////////////////////

	host_download_decoder u_decoder (
		.clk_25          (clk_25),
		.rst_n           (rst_n),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_index        (dl_index),
		.dl_data         (dl_data),
		.rom_wr          (rom_wr),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.dsw0            (dsw0),
		.dsw1            (dsw1),
		.game_battlezone (game_battlezone),
		.game_bradley    (game_bradley),
		.game_redbaron   (game_redbaron)
	);

	// Cabinet controls
	tank_stick_mapper u_stick (
		.clk_25      (clk_25),
		.rst_n       (rst_n),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.cab_buttons (cab_buttons)
	);

	// Reset, video and audio glue
	shell_control u_ctrl (
		.clk_25      (clk_25),
		.rst_n       (rst_n),
		.status      (status),
		.buttons     (buttons),
		.dl_download (dl_download),
		.game_audio  (game_audio),
		.core_rst_n  (core_rst_n),
		.self_test   (self_test),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.ce_pix      (ce_pix),
		.audio_l     (audio_l),
		.audio_r     (audio_r),
		.led_user    (led_user)
	);

endmodule

// File: source/host_download_decoder.sv
// Host download decoder: variant register, DIP switch bank, filtered ROM write port

`include "arcade_shell_consts.svh"

module host_download_decoder
	import arcade_shell_pkg::*;
(
	input  logic      clk_25,
	input  logic      rst_n,
	input  logic      dl_wr,
	input  dl_addr_t  dl_addr,
	input  dl_index_t dl_index,
	input  byte_t     dl_data,
	output logic      rom_wr,
	output dl_addr_t  rom_addr,
	output byte_t     rom_data,
	output byte_t     dsw0,
	output byte_t     dsw1,
	output logic      game_battlezone,
	output logic      game_bradley,
	output logic      game_redbaron
);

	// Stored variant code, 255 means no game selected
	byte_t mod_reg;
	byte_t mod_next;

	// Switch bank, all eight bytes kept
	byte_t sw_bank [`ARCADE_DIP_BYTES];

	// Write strobes per target
	logic wr_rom;
	logic wr_mod;
	logic wr_dip;

	assign wr_rom = dl_wr && (dl_index == `ARCADE_DL_INDEX_ROM);
	assign wr_mod = dl_wr && (dl_index == `ARCADE_DL_INDEX_MOD);
	// Upper address bits must be clear, anything at 8 or above is dropped
	assign wr_dip = dl_wr && (dl_index == `ARCADE_DL_INDEX_DIP) && (dl_addr[24:3] == '0);

	// Variant as it will be after this edge
	// Lets the one-hot selects follow in the same cycle as the register
	assign mod_next = wr_mod ? dl_data : mod_reg;

	//////////////////////////////////////////////////////////////////////
	// Variant register and game selects
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			mod_reg         <= 8'hFF;
			game_battlezone <= 1'b0;
			game_bradley    <= 1'b0;
			game_redbaron   <= 1'b0;
		end else begin
			mod_reg         <= mod_next;
			// Codes 0..2 pick a game, anything else leaves all low
			game_battlezone <= (mod_next == 8'd0);
			game_bradley    <= (mod_next == 8'd1);
			game_redbaron   <= (mod_next == 8'd2);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// DIP switch bank
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			for (int i = 0; i < `ARCADE_DIP_BYTES; i++) begin
				sw_bank[i] <= '0;
			end
		end else if (wr_dip) begin
			sw_bank[dl_addr[2:0]] <= dl_data;
		end
	end

	// Only the first two bytes go to the core
	assign dsw0 = sw_bank[0];
	assign dsw1 = sw_bank[1];

	//////////////////////////////////////////////////////////////////////
	// ROM write port
	//////////////////////////////////////////////////////////////////////

	// Strobe, one cycle per accepted host write
	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			rom_wr <= 1'b0;
		end else begin
			rom_wr <= wr_rom;
		end
	end

	// Address and data captured with the strobe
	always_ff @(posedge clk_25) begin
		if (wr_rom) begin
			rom_addr <= dl_addr;
			rom_data <= dl_data;
		end
	end

endmodule

// File: source/shell_control.sv
// Shell control: core reset sequencer, HDMI aspect, pixel enable, audio widening, LED

`include "arcade_shell_consts.svh"

module shell_control
	import arcade_shell_pkg::*;
(
	input  logic        clk_25,
	input  logic        rst_n,
	input  status_t     status,
	input  logic [1:0]  buttons,
	input  logic        dl_download,
	input  game_audio_t game_audio,
	output logic        core_rst_n,
	output logic        self_test,
	output ratio_t      video_arx,
	output ratio_t      video_ary,
	output logic        ce_pix,
	output sample_t     audio_l,
	output sample_t     audio_r,
	output logic        led_user
);

	localparam int unsigned STRETCH_W = $clog2(`ARCADE_RESET_STRETCH);
	localparam logic [STRETCH_W-1:0] STRETCH_LAST = STRETCH_W'(`ARCADE_RESET_STRETCH - 1);

	reset_state_t           rst_state;
	logic [STRETCH_W-1:0]   stretch_cnt;
	logic                   rst_src;
	logic [1:0]             ar;

	// Menu reset, OSD button or a download in progress
	assign rst_src = status[`ARCADE_STAT_RESET] | buttons[1] | dl_download;
	assign ar      = status[`ARCADE_STAT_AR_LO + 1 : `ARCADE_STAT_AR_LO];

	//////////////////////////////////////////////////////////////////////
	// Core reset FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			rst_state   <= RST_HOLD;
			stretch_cnt <= '0;
			core_rst_n  <= 1'b0;
		end else if (rst_src) begin
			// Any source restarts the whole sequence
			rst_state   <= RST_HOLD;
			stretch_cnt <= '0;
			core_rst_n  <= 1'b0;
		end else begin
			case (rst_state)
				RST_HOLD: begin
					rst_state   <= RST_STRETCH;
					stretch_cnt <= '0;
				end
				RST_STRETCH: begin
					if (stretch_cnt == STRETCH_LAST) begin
						rst_state  <= RST_RUN;
						core_rst_n <= 1'b1;
					end else begin
						stretch_cnt <= stretch_cnt + 1'b1;
					end
				end
				// Core running, stay here
				default: core_rst_n <= 1'b1;
			endcase
		end
	end

	// Pixel enable at half the clock
	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			ce_pix <= 1'b0;
		end else begin
			ce_pix <= ~ce_pix;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Video, audio and indicators
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_25) begin
		// Field 0 is the original monitor
		// Other values select the host's custom ratio slots
		if (ar == 2'd0) begin
			video_arx <= `ARCADE_ARX_ORIG;
			video_ary <= `ARCADE_ARY_ORIG;
		end else begin
			video_arx <= ratio_t'(ar) - 12'd1;
			video_ary <= '0;
		end
		// Nibble repeated into the top byte, same on both channels
		audio_l   <= {game_audio, game_audio, 8'h00};
		audio_r   <= {game_audio, game_audio, 8'h00};
		// Menu bit is active high, the core input active low
		self_test <= ~status[`ARCADE_STAT_SELFTEST];
		led_user  <= dl_download;
	end

endmodule

// File: source/tank_stick_mapper.sv
// Tank stick mapper: eight-way joystick to tread controls, cabinet button byte

module tank_stick_mapper
	import arcade_shell_pkg::*;
(
	input  logic  clk_25,
	input  logic  rst_n,
	input  joy_t  joy_0,
	input  joy_t  joy_1,
	output byte_t cab_buttons
);

	// Both players drive the same cabinet
	joy_t joy;

	// Tread controls, forward and back per side
	logic lt_fw;
	logic lt_bk;
	logic rt_fw;
	logic rt_bk;

	assign joy = joy_0 | joy_1;

	//////////////////////////////////////////////////////////////////////
	// Direction table
	//////////////////////////////////////////////////////////////////////

	// Bits: up, down, left, right
	always_comb begin
		lt_fw = 1'b0;
		lt_bk = 1'b0;
		rt_fw = 1'b0;
		rt_bk = 1'b0;
		case ({joy[3], joy[2], joy[1], joy[0]})
			// Up, drive straight ahead
			4'b1000: begin
				lt_fw = 1'b1;
				rt_fw = 1'b1;
			end
			// Down, straight back
			4'b0100: begin
				lt_bk = 1'b1;
				rt_bk = 1'b1;
			end
			// Right, spin clockwise
			4'b0001: begin
				lt_fw = 1'b1;
				rt_bk = 1'b1;
			end
			// Left, spin the other way
			4'b0010: begin
				lt_bk = 1'b1;
				rt_fw = 1'b1;
			end
			// Diagonals move one tread only
			4'b1001: lt_fw = 1'b1;
			4'b1010: rt_fw = 1'b1;
			4'b0101: lt_bk = 1'b1;
			4'b0110: rt_bk = 1'b1;
			// Conflicting or idle stick, tank stands still
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Button byte
	//////////////////////////////////////////////////////////////////////

	// Upper nibble: coin, start 2P, start 1P, fire
	always_ff @(posedge clk_25) begin
		if (!rst_n) begin
			cab_buttons <= '0;
		end else begin
			cab_buttons <= {joy[7], joy[5], joy[6], joy[4], lt_fw, lt_bk, rt_fw, rt_bk};
		end
	end

endmodule

// File: verification/arcade_shell_assert.sv
// Concurrent assertions on the arcade shell top: ROM strobe, game selects, core reset, pixel enable

module arcade_shell_assert (
	input logic clk_25,
	input logic rst_n,
	input logic rom_wr,
	input logic game_battlezone,
	input logic game_bradley,
	input logic game_redbaron,
	input logic dl_download,
	input logic core_rst_n,
	input logic ce_pix
);

	timeunit 1ns;
	timeprecision 100ps;

	// One host write gives one strobe
	rom_wr_single: assert property (@(posedge clk_25) rom_wr |=> !rom_wr)
		else $error("rom_wr high for two cycles");

	// Variant decode never picks two games
	game_select_onehot: assert property (@(posedge clk_25)
		$onehot0({game_battlezone, game_bradley, game_redbaron}))
		else $error("more than one game select high");

	// Core stays in reset for the whole download
	core_held_in_download: assert property (@(posedge clk_25) dl_download |=> !core_rst_n)
		else $error("core_rst_n high during a download");

	// Toggles on every edge taken out of reset
	ce_pix_toggles: assert property (@(posedge clk_25) $past(rst_n) |-> ce_pix != $past(ce_pix))
		else $error("ce_pix did not alternate");

endmodule

bind arcade_shell_top arcade_shell_assert u_assert (
	.clk_25          (clk_25),
	.rst_n           (rst_n),
	.rom_wr          (rom_wr),
	.game_battlezone (game_battlezone),
	.game_bradley    (game_bradley),
	.game_redbaron   (game_redbaron),
	.dl_download     (dl_download),
	.core_rst_n      (core_rst_n),
	.ce_pix          (ce_pix)
);

// File: verification/arcade_shell_input.txt
# op f1 f2 f3 e1 e2 e3, all hex. op 1 write: index addr data / rom_wr {dsw1,dsw0} {rb,bd,bz}
# op 2 joy_0 joy_1 / cab_buttons; op 3 status buttons / arx ary self_test; op 4 download / led core_rst_n; op 5 audio / l r; op 6 / release cycles
1 05 0000000 00 0 0000 0
2 0000 0000 0 00 0 0
# Stick table, bits up down left right
2 0008 0000 0 0A 0 0
2 0004 0000 0 05 0 0
2 0001 0000 0 09 0 0
2 0002 0000 0 06 0 0
2 0009 0000 0 08 0 0
2 0000 000A 0 02 0 0
2 0004 0001 0 04 0 0
2 0006 0000 0 01 0 0
2 000C 0000 0 00 0 0
2 0003 0000 0 00 0 0
# Coin, starts and fire in the upper nibble
2 0010 0000 0 10 0 0
2 0020 0000 0 40 0 0
2 0040 0000 0 20 0 0
2 0080 0000 0 80 0 0
2 0000 0018 0 1A 0 0
# Switch bank, address 8 is dropped
1 FE 0000000 A5 0 00A5 0
1 FE 0000001 3C 0 3CA5 0
1 FE 0000008 FF 0 3CA5 0
1 FE 0000002 77 0 3CA5 0
# Variant codes
1 01 0000000 00 0 3CA5 1
1 01 0000000 01 0 3CA5 2
1 01 0000000 02 0 3CA5 4
1 01 0000000 03 0 3CA5 0
# ROM port
1 00 0012345 5A 1 3CA5 0
1 00 1FFFFFF C3 1 3CA5 0
1 02 0000010 99 0 3CA5 0
# Reset sources, one register cycle plus sixteen of stretch
4 1 0 0 1 0 0
4 0 0 0 0 0 0
6 0 0 0 11 0 0
3 00000001 0 0 004 003 1
3 00000000 0 0 004 003 1
6 0 0 0 11 0 0
3 00000000 2 0 004 003 1
3 00000000 0 0 004 003 1
6 0 0 0 11 0 0
# Aspect field and audio
3 00004000 0 0 000 000 1
3 00008000 0 0 001 000 1
3 0000C008 0 0 002 000 0
5 0 0 0 0000 0000 0
5 A 0 0 AA00 AA00 0
5 3 0 0 3300 3300 0

// File: verification/arcade_shell_tb.sv
// Testbench for the arcade shell top: vector file stimulus, output checks, watchdog, summary

module arcade_shell_tb
	import arcade_shell_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_VECTORS = 256;
	// Watchdog budget per vector, in clock cycles
	localparam int CYCLES_PER_VECTOR = 40;
	// Longest wait for the core reset to drop
	localparam int RELEASE_LIMIT = 64;
	localparam string VECTOR_FILE = "verification/arcade_shell_input.txt";

	logic        clk_25;
	logic        rst_n;
	logic        dl_download;
	logic        dl_wr;
	dl_addr_t    dl_addr;
	dl_index_t   dl_index;
	byte_t       dl_data;
	status_t     status;
	logic [1:0]  buttons;
	joy_t        joy_0;
	joy_t        joy_1;
	game_audio_t game_audio;

	logic        rom_wr;
	dl_addr_t    rom_addr;
	byte_t       rom_data;
	byte_t       dsw0;
	byte_t       dsw1;
	logic        game_battlezone;
	logic        game_bradley;
	logic        game_redbaron;
	byte_t       cab_buttons;
	logic        self_test;
	logic        core_rst_n;
	ratio_t      video_arx;
	ratio_t      video_ary;
	logic        ce_pix;
	sample_t     audio_l;
	sample_t     audio_r;
	logic        led_user;

	// Columns per vector: op, three fields, three expected values
	logic [31:0] vectors [MAX_VECTORS][7];
	int          num_vectors;
	int          error_count;
	int          check_count;
	logic        vectors_ready;

	arcade_shell_top uut (
		.clk_25          (clk_25),
		.rst_n           (rst_n),
		.dl_download     (dl_download),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_index        (dl_index),
		.dl_data         (dl_data),
		.status          (status),
		.buttons         (buttons),
		.joy_0           (joy_0),
		.joy_1           (joy_1),
		.game_audio      (game_audio),
		.rom_wr          (rom_wr),
		.rom_addr        (rom_addr),
		.rom_data        (rom_data),
		.dsw0            (dsw0),
		.dsw1            (dsw1),
		.game_battlezone (game_battlezone),
		.game_bradley    (game_bradley),
		.game_redbaron   (game_redbaron),
		.cab_buttons     (cab_buttons),
		.self_test       (self_test),
		.core_rst_n      (core_rst_n),
		.video_arx       (video_arx),
		.video_ary       (video_ary),
		.ce_pix          (ce_pix),
		.audio_l         (audio_l),
		.audio_r         (audio_r),
		.led_user        (led_user)
	);

	initial begin
		clk_25 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_25 = ~clk_25;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// One edge for the DUT to register, then sample mid-cycle
	task automatic wait_one_cycle();
		@(posedge clk_25);
		@(negedge clk_25);
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] fld [7];
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			error_count++;
			$display("Cannot open the vector file %s", VECTOR_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// Comment lines start with a hash
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
				if (n == 7 && num_vectors < MAX_VECTORS) begin
					for (int c = 0; c < 7; c++) begin
						vectors[num_vectors][c] = fld[c];
					end
					num_vectors++;
				end else if (n > 0) begin
					error_count++;
					$display("Malformed or excess vector line: %s", line);
				end
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////////////////////////
	// One vector
	//////////////////////////////////////////////////////////////////////

	task automatic run_vector(
		input logic [31:0] op,
		input logic [31:0] f1,
		input logic [31:0] f2,
		input logic [31:0] f3,
		input logic [31:0] e1,
		input logic [31:0] e2,
		input logic [31:0] e3
	);
		int edges;
		case (op)
			// Host download write, strobe for one cycle
			32'd1: begin
				@(posedge clk_25);
				dl_wr    <= 1'b1;
				dl_index <= f1[7:0];
				dl_addr  <= f2[24:0];
				dl_data  <= f3[7:0];
				@(posedge clk_25);
				dl_wr <= 1'b0;
				@(negedge clk_25);
				compare_value("rom_wr", rom_wr, e1);
				if (e1 == 32'd1) begin
					compare_value("rom_addr", rom_addr, f2);
					compare_value("rom_data", rom_data, f3);
				end
				compare_value("dsw1_dsw0", {dsw1, dsw0}, e2);
				compare_value("game_select", {game_redbaron, game_bradley, game_battlezone}, e3);
				// Strobe must be gone a cycle later
				wait_one_cycle();
				compare_value("rom_wr_end", rom_wr, 32'd0);
			end
			32'd2: begin
				@(posedge clk_25);
				joy_0 <= f1[15:0];
				joy_1 <= f2[15:0];
				wait_one_cycle();
				compare_value("cab_buttons", cab_buttons, e1);
			end
			32'd3: begin
				@(posedge clk_25);
				status  <= f1;
				buttons <= f2[1:0];
				wait_one_cycle();
				compare_value("video_arx", video_arx, e1);
				compare_value("video_ary", video_ary, e2);
				compare_value("self_test", self_test, e3);
			end
			32'd4: begin
				@(posedge clk_25);
				dl_download <= f1[0];
				wait_one_cycle();
				compare_value("led_user", led_user, e1);
				compare_value("core_rst_n", core_rst_n, e2);
			end
			32'd5: begin
				@(posedge clk_25);
				game_audio <= f1[3:0];
				wait_one_cycle();
				compare_value("audio_l", audio_l, e1);
				compare_value("audio_r", audio_r, e2);
			end
			// Count edges since the previous drive until the core leaves reset
			32'd6: begin
				edges = 1;
				while (!core_rst_n && edges < RELEASE_LIMIT) begin
					wait_one_cycle();
					edges++;
				end
				if (!core_rst_n) begin
					error_count++;
					$display("Core reset still held after %0d cycles", edges);
				end else begin
					compare_value("release_cycles", edges, e1);
				end
			end
			default: begin
				error_count++;
				$display("Unknown operation code %0h in the vector file", op);
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		wait (vectors_ready === 1'b1);
		#((num_vectors * CYCLES_PER_VECTOR + RESET_CYCLES) * CLK_PERIOD);
		$display("Timeout, the vectors did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	// Pixel enable leaves reset low and flips on every clock
	initial begin
		int cycle;
		cycle = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk_25);
			compare_value("ce_pix", ce_pix, cycle % 2);
			cycle++;
		end
	end

	initial begin
		vectors_ready = 1'b0;
		num_vectors   = 0;
		error_count   = 0;
		check_count   = 0;
		rst_n       <= 1'b0;
		dl_download <= 1'b0;
		dl_wr       <= 1'b0;
		dl_addr     <= '0;
		dl_index    <= '0;
		dl_data     <= '0;
		status      <= '0;
		buttons     <= '0;
		joy_0       <= '0;
		joy_1       <= '0;
		game_audio  <= '0;
		load_vectors();
		if (num_vectors == 0) begin
			error_count++;
			$display("No vectors were loaded");
		end
		vectors_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_25);
		rst_n <= 1'b1;
		for (int i = 0; i < num_vectors; i++) begin
			run_vector(vectors[i][0], vectors[i][1], vectors[i][2], vectors[i][3],
				vectors[i][4], vectors[i][5], vectors[i][6]);
		end
		$display("Summary: vectors=%0d checks=%0d errors=%0d",
			num_vectors, check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/arcade_shell_pkg.sv
source/host_download_decoder.sv
source/tank_stick_mapper.sv
source/shell_control.sv
source/arcade_shell_top.sv
verification/arcade_shell_assert.sv
verification/arcade_shell_tb.sv
